// ==== filelist.f ====
+incdir+design
design/lc3b_types.sv
design/mem_port_if.sv
design/arbiter_control.sv
design/arbiter_datapath.sv
design/arbiter.sv
design/access_timer.sv
design/line_memory.sv
design/mem_subsystem.sv
verif/clk_gen.sv
verif/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - design
    files:
      - design/lc3b_types.sv
      - design/mem_port_if.sv
      - design/arbiter_control.sv
      - design/arbiter_datapath.sv
      - design/arbiter.sv
      - design/access_timer.sv
      - design/line_memory.sv
      - design/mem_subsystem.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/clk_gen.sv
      - verif/tb_mem_subsystem.sv

// ==== verif/tb_mem_subsystem.sv ====
// Testbench for mem_subsystem; two random clients checked against a reference line memory
`timescale 1ns/10ps
`include "arbiter_cfg.svh"

module tb_mem_subsystem;
    import lc3b_types::*;

    localparam int SEED      = 32'hfa8c_b8fa;
    localparam int NUM_LINES = 1 << `MEM_LINES_LOG2;
    localparam int N_RANDOM  = 200;
    // Directed accesses plus the random run
    localparam int N_ACCESS   = 16 + 16 + 2 + 4 + N_RANDOM;
    localparam int MAX_CYCLES = N_ACCESS * (2 * `MEM_LATENCY + 6) + 500;

    logic          clk;
    logic          rst;
    lc3b_word      address [1:2];
    lc3b_cacheline wdata   [1:2];
    lc3b_cacheline rdata   [1:2];
    logic [2:1]    rd_s;
    logic [2:1]    wr_s;
    logic [2:1]    resp;

    lc3b_cacheline ref_mem [NUM_LINES];
    bit            written [NUM_LINES];
    logic [2:1]    pending;
    int            requests [1:2];
    int            resps [1:2];
    int            resp_cycle [1:2];
    int            seed1;
    int            seed2;
    int            cycles = 0;
    int            checks = 0;
    int            errors = 0;
    int            test_mark = 0;

    clk_gen #(.PERIOD(40), .RST_CYCLES(4)) clocks (.clk, .rst);

    mem_subsystem DUT (
        .clk, .rst,
        .p1_address (address[1]), .p1_wdata (wdata[1]), .p1_read (rd_s[1]),
        .p1_write   (wr_s[1]),    .p1_resp  (resp[1]),  .p1_rdata (rdata[1]),
        .p2_address (address[2]), .p2_wdata (wdata[2]), .p2_read (rd_s[2]),
        .p2_write   (wr_s[2]),    .p2_resp  (resp[2]),  .p2_rdata (rdata[2])
    );

    // Model index, bits just above the 4-bit offset
    function automatic line_index_t line_of(input lc3b_word addr);
        return addr[4 +: `MEM_LINES_LOG2];
    endfunction

    function automatic logic [31:0] next_random(input int c);
        if (c == 1) begin
            return $random(seed1);
        end
        return $random(seed2);
    endfunction

    function automatic lc3b_cacheline rand_line(input int c);
        return {next_random(c), next_random(c), next_random(c), next_random(c)};
    endfunction

    task automatic check_line(input string name, input lc3b_cacheline got,
                              input lc3b_cacheline exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_mark);
        test_mark = errors;
    endtask

    // One access, level held until resp; the model is updated or checked in the resp cycle
    task automatic run_access(input int c, input logic wr, input lc3b_word addr,
                              input lc3b_cacheline data);
        line_index_t idx;
        idx = line_of(addr);
        @(posedge clk);
        address[c] <= addr;
        wdata[c]   <= data;
        rd_s[c]    <= !wr;
        wr_s[c]    <= wr;
        pending[c] = 1'b1;
        requests[c]++;
        do @(negedge clk); while (resp[c] !== 1'b1);
        if (wr) begin
            ref_mem[idx] = data;
            written[idx] = 1'b1;
        end else if (written[idx]) begin
            check_line(c == 1 ? "p1_rdata" : "p2_rdata", rdata[c], ref_mem[idx]);
        end
        @(posedge clk);
        rd_s[c]    <= 1'b0;
        wr_s[c]    <= 1'b0;
        pending[c] = 1'b0;
    endtask

    task automatic write_read_test(input int c);
        lc3b_word addrs [8];
        for (int i = 0; i < 8; i++) begin
            addrs[i] = lc3b_word'(next_random(c));
            run_access(c, 1'b1, addrs[i], rand_line(c));
        end
        for (int i = 0; i < 8; i++) begin
            run_access(c, 1'b0, addrs[i], '0);
        end
    endtask

    task automatic random_client(input int c, input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = next_random(c);
            run_access(c, r[0], lc3b_word'(next_random(c)), rand_line(c));
            repeat (r[2:1]) @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // Resp is sampled mid-cycle, away from the edges that move it
    always @(negedge clk) begin
        if (!rst) begin
            for (int c = 1; c <= 2; c++) begin
                if (resp[c] === 1'b1) begin
                    resps[c]++;
                    resp_cycle[c] = cycles;
                    if (!pending[c]) begin
                        errors++;
                        $display("client %0d got a resp with no request pending", c);
                    end
                end
            end
        end
    end

    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("timeout after %0d cycles, a request never got its resp", cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        lc3b_word base;
        seed1 = SEED;
        // Data side runs its own stream derived from the same seed
        seed2 = SEED ^ 32'h0000_0001;
        for (int c = 1; c <= 2; c++) begin
            address[c]  = '0;
            wdata[c]    = '0;
            requests[c] = 0;
            resps[c]    = 0;
        end
        rd_s    = '0;
        wr_s    = '0;
        pending = '0;
        wait (rst === 1'b0);

        repeat (10) begin
            @(negedge clk);
            check_flag("p1_resp", resp[1], 1'b0);
            check_flag("p2_resp", resp[2], 1'b0);
        end
        end_test("reset_quiet");

        write_read_test(1);
        end_test("p1_write_read");
        write_read_test(2);
        end_test("p2_write_read");

        // Both strobes rise on the same edge
        fork
            run_access(1, 1'b1, lc3b_word'(next_random(1)), rand_line(1));
            run_access(2, 1'b1, lc3b_word'(next_random(2)), rand_line(2));
        join
        check_flag("p1_resp_before_p2_resp", resp_cycle[1] < resp_cycle[2], 1'b1);
        end_test("same_cycle_priority");

        base = lc3b_word'(next_random(1));
        run_access(1, 1'b1, base, rand_line(1));
        run_access(2, 1'b0, base ^ 16'h000f, '0);
        run_access(2, 1'b1, base ^ (16'h0001 << (4 + `MEM_LINES_LOG2)), rand_line(2));
        run_access(1, 1'b0, base, '0);
        end_test("address_alias");

        fork
            random_client(1, N_RANDOM / 2);
            random_client(2, N_RANDOM / 2);
        join
        check_flag("p1_one_resp_per_request", resps[1] == requests[1], 1'b1);
        check_flag("p2_one_resp_per_request", resps[2] == requests[2], 1'b1);
        end_test("random_mixed");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_mem_subsystem

// ==== verif/clk_gen.sv ====
// Testbench clock and synchronous reset source; instantiate once in the testbench top
`timescale 1ns/10ps

module clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset drops on a rising edge, like any other synchronous input
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule : clk_gen

// ==== design/mem_subsystem.sv ====
// Top level of the memory subsystem; two L1 client ports shared onto one line memory
`timescale 1ns/10ps

module mem_subsystem (
    input  logic                      clk,
    input  logic                      rst,
    input  lc3b_types::lc3b_word      p1_address,
    input  lc3b_types::lc3b_cacheline p1_wdata,
    input  logic                      p1_read,
    input  logic                      p1_write,
    output logic                      p1_resp,
    output lc3b_types::lc3b_cacheline p1_rdata,
    input  lc3b_types::lc3b_word      p2_address,
    input  lc3b_types::lc3b_cacheline p2_wdata,
    input  logic                      p2_read,
    input  logic                      p2_write,
    output logic                      p2_resp,
    output lc3b_types::lc3b_cacheline p2_rdata
);

    mem_port_if mem_bus ();

    // Instruction side is p1, data side is p2
    arbiter arb (
        .clk,
        .rst,
        .p1_address,
        .p1_wdata,
        .p1_read,
        .p1_write,
        .p2_address,
        .p2_wdata,
        .p2_read,
        .p2_write,
        .p1_resp,
        .p2_resp,
        .p1_rdata,
        .p2_rdata,
        .mem (mem_bus)
    );

    line_memory memory (
        .clk,
        .rst,
        .mem (mem_bus)
    );

endmodule : mem_subsystem

// ==== design/line_memory.sv ====
// Stand-in for the L2 cache; line-wide storage answering reads and writes after a fixed delay
`timescale 1ns/10ps
`include "arbiter_cfg.svh"

module line_memory (
    input  logic      clk,
    input  logic      rst,
    mem_port_if.slave mem
);
    import lc3b_types::*;

    localparam int OFFSET_W  = 4;
    localparam int NUM_LINES = 1 << `MEM_LINES_LOG2;

    lc3b_cacheline lines [NUM_LINES];
    line_index_t   index;
    logic          busy;
    logic          done;

    // Bits above the line index are ignored
    assign index = mem.address[OFFSET_W +: `MEM_LINES_LOG2];

    access_timer timer (
        .clk,
        .rst,
        .start (mem.read | mem.write),
        .busy,
        .done
    );

    // Write lands in the resp cycle
    always_ff @(posedge clk) begin
        if (done && mem.write) begin
            lines[index] <= mem.wdata;
        end
    end

    assign mem.rdata = lines[index];
    assign mem.resp  = done;

    // Arbiter must hold the granted address for the whole access
    assert property (@(posedge clk) disable iff (rst) busy |-> $stable(mem.address));

endmodule : line_memory

// ==== design/access_timer.sv ====
// Latency counter for the line memory; busy while an access runs, done pulses when it may end
`timescale 1ns/10ps
`include "arbiter_cfg.svh"

module access_timer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic busy,
    output logic done
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [CNT_W-1:0] count_q;

    // Last counted cycle of the access
    assign done = busy && (count_q == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            count_q <= '0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                count_q <= CNT_W'(`MEM_LATENCY);
            end
        end else if (done) begin
            busy <= 1'b0;
        end else begin
            count_q <= count_q - 1'b1;
        end
    end

    // Requester must drop its strobe right after the answer
    assert property (@(posedge clk) disable iff (rst) done |=> !start);

endmodule : access_timer

// ==== design/arbiter.sv ====
// Two-client arbiter for the line-wide memory port; capture stage, grant FSM and steering
`timescale 1ns/10ps

module arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  lc3b_types::lc3b_word      p1_address,
    input  lc3b_types::lc3b_cacheline p1_wdata,
    input  logic                      p1_read,
    input  logic                      p1_write,
    input  lc3b_types::lc3b_word      p2_address,
    input  lc3b_types::lc3b_cacheline p2_wdata,
    input  logic                      p2_read,
    input  logic                      p2_write,
    output logic                      p1_resp,
    output logic                      p2_resp,
    output lc3b_types::lc3b_cacheline p1_rdata,
    output lc3b_types::lc3b_cacheline p2_rdata,
    mem_port_if.master                mem
);
    import lc3b_types::*;

    lc3b_word      p1_address_q;
    lc3b_word      p2_address_q;
    lc3b_cacheline p1_wdata_q;
    lc3b_cacheline p2_wdata_q;
    logic          p1_read_q;
    logic          p1_write_q;
    logic          p2_read_q;
    logic          p2_write_q;
    logic          grant_p2;
    logic          access;

    // Strobes are gated by access and cleared by the client's own resp
    always_ff @(posedge clk) begin
        if (rst) begin
            p1_read_q  <= 1'b0;
            p1_write_q <= 1'b0;
            p2_read_q  <= 1'b0;
            p2_write_q <= 1'b0;
        end else begin
            p1_read_q  <= p1_read & access & ~p1_resp;
            p1_write_q <= p1_write & access & ~p1_resp;
            p2_read_q  <= p2_read & access & ~p2_resp;
            p2_write_q <= p2_write & access & ~p2_resp;
        end
    end

    // Payload follows the client every cycle
    always_ff @(posedge clk) begin
        p1_address_q <= p1_address;
        p1_wdata_q   <= p1_wdata;
        p2_address_q <= p2_address;
        p2_wdata_q   <= p2_wdata;
    end

    arbiter_control control (
        .clk,
        .rst,
        .p1_req   (p1_read_q | p1_write_q),
        .p2_req   (p2_read_q | p2_write_q),
        .mem_resp (mem.resp),
        .grant_p2,
        .access
    );

    arbiter_datapath datapath (
        .grant_p2,
        .p1_address (p1_address_q),
        .p1_wdata   (p1_wdata_q),
        .p1_read    (p1_read_q),
        .p1_write   (p1_write_q),
        .p2_address (p2_address_q),
        .p2_wdata   (p2_wdata_q),
        .p2_read    (p2_read_q),
        .p2_write   (p2_write_q),
        .mem,
        .p1_resp,
        .p2_resp,
        .p1_rdata,
        .p2_rdata
    );

endmodule : arbiter

// ==== design/arbiter_datapath.sv ====
// Arbiter steering; drives the memory port from the granted client and returns resp to it
`timescale 1ns/10ps

module arbiter_datapath (
    input  logic                     grant_p2,
    input  lc3b_types::lc3b_word     p1_address,
    input  lc3b_types::lc3b_cacheline p1_wdata,
    input  logic                     p1_read,
    input  logic                     p1_write,
    input  lc3b_types::lc3b_word     p2_address,
    input  lc3b_types::lc3b_cacheline p2_wdata,
    input  logic                     p2_read,
    input  logic                     p2_write,
    mem_port_if.master               mem,
    output logic                     p1_resp,
    output logic                     p2_resp,
    output lc3b_types::lc3b_cacheline p1_rdata,
    output lc3b_types::lc3b_cacheline p2_rdata
);

    // Request side follows the grant
    assign mem.address = grant_p2 ? p2_address : p1_address;
    assign mem.wdata   = grant_p2 ? p2_wdata   : p1_wdata;
    assign mem.read    = grant_p2 ? p2_read    : p1_read;
    assign mem.write   = grant_p2 ? p2_write   : p1_write;

    // Only the owner sees the pulse
    assign p1_resp = mem.resp & ~grant_p2;
    assign p2_resp = mem.resp & grant_p2;

    // Data goes to both, resp tells which one it is for
    assign p1_rdata = mem.rdata;
    assign p2_rdata = mem.rdata;

endmodule : arbiter_datapath

// ==== design/arbiter_control.sv ====
// Grant FSM of the arbiter; picks one client per access and blocks new captures after it ends
`timescale 1ns/10ps

module arbiter_control (
    input  logic clk,
    input  logic rst,
    input  logic p1_req,
    input  logic p2_req,
    input  logic mem_resp,
    output logic grant_p2,
    output logic access
);
    import lc3b_types::*;

    arbiter_state_t state_q;
    arbiter_state_t state_d;
    logic           grant_q;
    logic           release_q;

    // Winner is picked in idle so its strobe reaches memory in the same cycle
    always_comb begin
        grant_p2 = grant_q;
        if (state_q == st_idle) begin
            if (p1_req) begin
                grant_p2 = 1'b0;
            end else if (p2_req) begin
                grant_p2 = 1'b1;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (p1_req) begin
                    state_d = st_serve_p1;
                end else if (p2_req) begin
                    state_d = st_serve_p2;
                end
            end
            st_serve_p1, st_serve_p2: begin
                if (mem_resp) begin
                    state_d = st_release;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= st_idle;
            grant_q   <= 1'b0;
            release_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            grant_q   <= grant_p2;
            release_q <= (state_q == st_release);
        end
    end

    // Two-cycle gap so the finished client can drop its level
    assign access = (state_q != st_release) && !release_q;

    // Port stays with the client being served for the whole access
    assert property (@(posedge clk) disable iff (rst)
        (state_q == st_serve_p1 || state_q == st_serve_p2)
        |-> (grant_p2 == (state_q == st_serve_p2)));

    // Memory only answers a strobe that was granted
    assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (state_q != st_idle));

endmodule : arbiter_control

// ==== design/mem_port_if.sv ====
// Line-wide request/response port; the arbiter drives it as master, the line memory as slave
`timescale 1ns/10ps

interface mem_port_if;
    import lc3b_types::*;

    lc3b_word      address;
    lc3b_cacheline wdata;
    logic          read;
    logic          write;
    lc3b_cacheline rdata;
    logic          resp;

    // Requester holds strobe, address and wdata until resp
    modport master (
        output address,
        output wdata,
        output read,
        output write,
        input  rdata,
        input  resp
    );

    // Memory answers with a one-cycle resp, rdata valid in that cycle
    modport slave (
        input  address,
        input  wdata,
        input  read,
        input  write,
        output rdata,
        output resp
    );

endinterface : mem_port_if

// ==== design/lc3b_types.sv ====
// Word, line, line-index and arbiter state types shared by the memory subsystem; import where used
`include "arbiter_cfg.svh"

package lc3b_types;

    // Byte address of one LC-3b word
    typedef logic [15:0] lc3b_word;

    // Eight words, the unit moved between caches and memory
    typedef logic [127:0] lc3b_cacheline;

    // Line number taken from the address bits just above the 4-bit offset
    typedef logic [`MEM_LINES_LOG2-1:0] line_index_t;

    // Grant FSM of the arbiter
    typedef enum logic [1:0] {
        st_idle,
        st_serve_p1,
        st_serve_p2,
        st_release
    } arbiter_state_t;

endpackage : lc3b_types

// ==== design/arbiter_cfg.svh ====
// Memory depth and latency settings; include in any file that sizes or times the line memory
`ifndef ARBITER_CFG_SVH
`define ARBITER_CFG_SVH

// Log2 of the number of lines held by the line memory
`define MEM_LINES_LOG2 6

// Cycles from an accepted strobe to the resp pulse, at least 1
`define MEM_LATENCY 5

`endif
